// ==== hdl/freelist_params.svh ====
// Size macros for the free list manager, included by the package, every RTL file and the testbench
`ifndef FREELIST_PARAMS_SVH
`define FREELIST_PARAMS_SVH

// Number of entry IDs in the pool
`define FL_NUM_ENTRIES 8
// Allocation symbols offered per cycle on the multi-transfer port
`define FL_NUM_ALLOC 2
// Independent deallocation ports, each a single-cycle strobe
`define FL_NUM_DEALLOC 2
// Width of one entry ID
`define FL_ENTRY_ID_W 3
// Width of a count from 0 to FL_NUM_ALLOC
`define FL_ALLOC_COUNT_W 2
// Width of a count from 0 to FL_NUM_DEALLOC
`define FL_DEALLOC_COUNT_W 2
// Entries held by the user out of reset, entries 0 and 1
`define FL_PREALLOC 8'h03
// Cycles from a deallocation strobe to its report on dealloc_count
// Kept equal to the cut-through latency so credits never run ahead of the pool
`define FL_DEALLOC_COUNT_DELAY 2

`endif

// ==== hdl/freelist_pkg.sv ====
// Shared types of the free list manager, referenced by scoped name from the RTL and testbench
`include "freelist_params.svh"

package freelist_pkg;

  // One entry ID in binary
  typedef logic [`FL_ENTRY_ID_W-1:0] entry_id_t;

  // One bit per pool entry, bit i stands for entry i
  typedef logic [`FL_NUM_ENTRIES-1:0] entry_vec_t;

  // Number of allocation symbols offered or taken in one cycle
  typedef logic [`FL_ALLOC_COUNT_W-1:0] alloc_count_t;

  // Number of deallocations seen in one cycle
  typedef logic [`FL_DEALLOC_COUNT_W-1:0] dealloc_count_t;

  // All allocation symbols of one cycle, symbol 0 in the low bits
  typedef entry_id_t [`FL_NUM_ALLOC-1:0] alloc_ids_t;

  // All deallocation port IDs of one cycle, port 0 in the low bits
  typedef entry_id_t [`FL_NUM_DEALLOC-1:0] dealloc_ids_t;

endpackage

// ==== hdl/freelist_dealloc_decode.sv ====
// Deallocation decode, turning the strobed return ports into a set-vector and a delayed count
`timescale 1ns/10ps
`include "freelist_params.svh"

module freelist_dealloc_decode (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`FL_NUM_DEALLOC-1:0]   dealloc_valid,
  input  freelist_pkg::dealloc_ids_t   dealloc_ids,
  output freelist_pkg::entry_vec_t     returned_vec,
  output freelist_pkg::dealloc_count_t dealloc_count
);

  // Number of valid strobes in the current cycle
  freelist_pkg::dealloc_count_t count_now;

  // Delay line for the return count, stage 0 is the youngest
  freelist_pkg::dealloc_count_t count_pipe [`FL_DEALLOC_COUNT_DELAY];

  // Each valid port contributes the one-hot of its ID
  // The user never returns one ID on two ports, so OR is exact
  always_comb begin
    returned_vec = '0;
    for (int i = 0; i < `FL_NUM_DEALLOC; i++) begin
      if (dealloc_valid[i]) begin
        returned_vec[dealloc_ids[i]] = 1'b1;
      end
    end
  end

  // Population count of the valid strobes
  always_comb begin
    count_now = '0;
    for (int i = 0; i < `FL_NUM_DEALLOC; i++) begin
      count_now = count_now + freelist_pkg::dealloc_count_t'(dealloc_valid[i]);
    end
  end

  // The count lands on the output exactly FL_DEALLOC_COUNT_DELAY cycles later
  // Every stage clears on reset so no stale count is reported
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `FL_DEALLOC_COUNT_DELAY; i++) begin
        count_pipe[i] <= '0;
      end
    end else begin
      count_pipe[0] <= count_now;
      for (int i = 1; i < `FL_DEALLOC_COUNT_DELAY; i++) begin
        count_pipe[i] <= count_pipe[i-1];
      end
    end
  end

  // Oldest stage is the reported count, zero in cycles without a matching strobe
  assign dealloc_count = count_pipe[`FL_DEALLOC_COUNT_DELAY-1];

endmodule

// ==== hdl/freelist_free_vector.sv ====
// Free entry register with lowest-first selection, feeding free IDs into the staging buffer
`timescale 1ns/10ps
`include "freelist_params.svh"

module freelist_free_vector (
  input  logic                       clk,
  input  logic                       rst_n,
  input  freelist_pkg::entry_vec_t   returned_vec,
  input  freelist_pkg::alloc_count_t push_receivable,
  output freelist_pkg::alloc_ids_t   push_ids,
  output freelist_pkg::alloc_count_t push_sendable
);

  // Entries that are free and not yet sitting in the staging buffer
  freelist_pkg::entry_vec_t free_q;
  freelist_pkg::entry_vec_t free_next;

  // Lowest free entry, as one-hot and binary
  freelist_pkg::entry_vec_t first_onehot;
  freelist_pkg::entry_id_t  first_id;
  logic                     first_valid;

  // Second-lowest free entry, as one-hot and binary
  freelist_pkg::entry_vec_t second_onehot;
  freelist_pkg::entry_id_t  second_id;
  logic                     second_valid;

  // Entries taken by the staging buffer at the coming edge
  freelist_pkg::entry_vec_t clear_vec;

  // Two-result priority selection over the free register
  // Scanning upward, the first set bit wins result 0 and the next one result 1
  always_comb begin
    first_onehot  = '0;
    first_id      = '0;
    first_valid   = 1'b0;
    second_onehot = '0;
    second_id     = '0;
    second_valid  = 1'b0;
    for (int i = 0; i < `FL_NUM_ENTRIES; i++) begin
      if (free_q[i]) begin
        if (!first_valid) begin
          first_valid     = 1'b1;
          first_onehot[i] = 1'b1;
          first_id        = freelist_pkg::entry_id_t'(i);
        end else if (!second_valid) begin
          second_valid     = 1'b1;
          second_onehot[i] = 1'b1;
          second_id        = freelist_pkg::entry_id_t'(i);
        end
      end
    end
  end

  // Symbol 0 carries the lowest entry, symbol 1 the next one
  assign push_ids[0] = first_id;
  assign push_ids[1] = second_id;

  // A second result implies a first, so the count is a plain sum capped at two
  assign push_sendable = freelist_pkg::alloc_count_t'(first_valid)
                       + freelist_pkg::alloc_count_t'(second_valid);

  // Only the symbols below push_receivable leave the register
  // An invalid result has an all-zero one-hot and clears nothing
  always_comb begin
    clear_vec = '0;
    if (push_receivable > 2'd0) begin
      clear_vec = clear_vec | first_onehot;
    end
    if (push_receivable > 2'd1) begin
      clear_vec = clear_vec | second_onehot;
    end
  end

  // Returned entries come back in, staged ones drop out
  // A returned entry is held by the user, so it is never among the cleared ones
  assign free_next = (free_q | returned_vec) & ~clear_vec;

  // Out of reset every entry except the preallocated ones is free
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      free_q <= ~`FL_PREALLOC;
    end else begin
      free_q <= free_next;
    end
  end

endmodule

// ==== hdl/freelist_alloc_stage.sv ====
// Registered two-slot staging buffer that offers entry IDs on the multi-transfer allocation port
`timescale 1ns/10ps
`include "freelist_params.svh"

module freelist_alloc_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  freelist_pkg::alloc_ids_t   push_ids,
  input  freelist_pkg::alloc_count_t push_sendable,
  output freelist_pkg::alloc_count_t push_receivable,
  input  freelist_pkg::alloc_count_t alloc_receivable,
  output freelist_pkg::alloc_count_t alloc_sendable,
  output freelist_pkg::alloc_ids_t   alloc_ids
);

  // Staged IDs, slot 0 is always the oldest and is offered on symbol 0
  freelist_pkg::alloc_ids_t   slot_q;
  freelist_pkg::alloc_ids_t   slot_next;

  // Number of valid slots, counted from slot 0 upward
  freelist_pkg::alloc_count_t occ_q;
  freelist_pkg::alloc_count_t occ_next;

  // Symbols the user takes this cycle
  freelist_pkg::alloc_count_t pop_count;

  // Slots still holding an ID once the pop is done
  freelist_pkg::alloc_count_t remain;

  // New IDs accepted from the free vector this cycle
  freelist_pkg::alloc_count_t push_count;

  // The user takes the smaller of what is offered and what it can receive
  assign pop_count = (alloc_receivable < occ_q) ? alloc_receivable : occ_q;
  assign remain    = occ_q - pop_count;

  // Free slots after the pop are offered back to the free vector
  assign push_receivable = freelist_pkg::alloc_count_t'(`FL_NUM_ALLOC) - remain;

  // Push transfers follow the same min rule as the outside port
  assign push_count = (push_sendable < push_receivable) ? push_sendable : push_receivable;

  // Survivors shift down by the pop count, pushes fill in right above them
  // With nothing popped and nothing pushed every slot keeps its value
  always_comb begin
    slot_next = slot_q;
    for (int i = 0; i < `FL_NUM_ALLOC; i++) begin
      if (i < int'(remain)) begin
        // Survivor i comes from slot i + pop_count, which is below occ_q
        slot_next[i] = slot_q[i + int'(pop_count)];
      end else if ((i - int'(remain)) < int'(push_count)) begin
        slot_next[i] = push_ids[i - int'(remain)];
      end
    end
  end

  // Occupancy never exceeds FL_NUM_ALLOC since push_count is bounded by free slots
  assign occ_next = remain + push_count;

  // The occupancy count is control state and clears on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_next;
    end
  end

  // Slot contents are only meaningful below occ_q
  always_ff @(posedge clk) begin
    slot_q <= slot_next;
  end

  // Outputs come straight from registers
  assign alloc_sendable = occ_q;
  assign alloc_ids      = slot_q;

endmodule

// ==== hdl/freelist_top.sv ====
// Top level of the free list manager, connecting decode, free vector and staging to the ports
`timescale 1ns/10ps
`include "freelist_params.svh"

module freelist_top (
  input  logic                         clk,
  input  logic                         rst_n,
  // Allocation port, min of sendable and receivable symbols transfer each cycle
  input  freelist_pkg::alloc_count_t   alloc_receivable,
  output freelist_pkg::alloc_count_t   alloc_sendable,
  output freelist_pkg::alloc_ids_t     alloc_ids,
  // Deallocation ports, single-cycle strobes without back-pressure
  input  logic [`FL_NUM_DEALLOC-1:0]   dealloc_valid,
  input  freelist_pkg::dealloc_ids_t   dealloc_ids,
  // Number of entries returned, reported FL_DEALLOC_COUNT_DELAY cycles later
  output freelist_pkg::dealloc_count_t dealloc_count
);

  // Entries handed back by the user this cycle
  freelist_pkg::entry_vec_t   returned_vec;

  // Push side between the free vector and the staging buffer
  freelist_pkg::alloc_ids_t   push_ids;
  freelist_pkg::alloc_count_t push_sendable;
  freelist_pkg::alloc_count_t push_receivable;

  // Decode stage turns return strobes into set bits and a delayed count
  freelist_dealloc_decode i_dealloc_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .dealloc_valid (dealloc_valid),
    .dealloc_ids   (dealloc_ids),
    .returned_vec  (returned_vec),
    .dealloc_count (dealloc_count)
  );

  // Execute stage keeps the free register and picks the lowest entries
  freelist_free_vector i_free_vector (
    .clk             (clk),
    .rst_n           (rst_n),
    .returned_vec    (returned_vec),
    .push_receivable (push_receivable),
    .push_ids        (push_ids),
    .push_sendable   (push_sendable)
  );

  // Result stage registers the picked IDs and offers them to the user
  freelist_alloc_stage i_alloc_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .push_ids         (push_ids),
    .push_sendable    (push_sendable),
    .push_receivable  (push_receivable),
    .alloc_receivable (alloc_receivable),
    .alloc_sendable   (alloc_sendable),
    .alloc_ids        (alloc_ids)
  );

endmodule

// ==== verif/freelist_tb.sv ====
// Table-driven testbench for the free list manager that build.f compiles as the top module
`timescale 1ns/10ps
`include "freelist_params.svh"

module freelist_tb;

  localparam int NUM_ROWS     = 12;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;

  // Deallocation modes of a table row where one and two equal the number of ports strobed
  localparam int D_NONE   = 0;
  localparam int D_ONE    = 1;
  localparam int D_TWO    = 2;
  localparam int D_RANDOM = 3;

  // Receivable value that asks for a fresh random choice each cycle
  localparam int R_RANDOM = -1;
  // Expected value that is left unchecked
  localparam int ANY = -1;

  logic                         clk;
  logic                         rst_n;
  freelist_pkg::alloc_count_t   alloc_receivable;
  freelist_pkg::alloc_count_t   alloc_sendable;
  freelist_pkg::alloc_ids_t     alloc_ids;
  logic [`FL_NUM_DEALLOC-1:0]   dealloc_valid;
  freelist_pkg::dealloc_ids_t   dealloc_ids;
  freelist_pkg::dealloc_count_t dealloc_count;

  // Stimulus table with one index per row
  string row_name    [NUM_ROWS];
  int    row_cycles  [NUM_ROWS];
  int    row_recv    [NUM_ROWS];
  int    row_dmode   [NUM_ROWS];
  int    row_exp_s   [NUM_ROWS];
  int    row_exp_id0 [NUM_ROWS];
  int    row_exp_id1 [NUM_ROWS];
  bit    row_drain   [NUM_ROWS];
  bit    row_account [NUM_ROWS];

  // Reference model of the IDs the user holds and the counts still in flight
  logic [`FL_NUM_ENTRIES-1:0] prealloc_mask;
  bit          held [`FL_NUM_ENTRIES];
  int          count_q [$];
  int          drained_q [$];
  // Outputs seen in the latest cycle and what was left of the previous offer
  int          last_s;
  int          last_ids [`FL_NUM_ALLOC];
  int          prev_ids [`FL_NUM_ALLOC];
  int          prev_n;
  int          prev_left;
  logic [31:0] rng;
  int          checks;
  int          errors;
  bit          table_ready;

  freelist_top i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .alloc_receivable (alloc_receivable),
    .alloc_sendable   (alloc_sendable),
    .alloc_ids        (alloc_ids),
    .dealloc_valid    (dealloc_valid),
    .dealloc_ids      (dealloc_ids),
    .dealloc_count    (dealloc_count)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // 32-bit xorshift step that never reaches zero from a nonzero seed
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare(input string name, input int actual, input int expected);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t ns", name, actual, expected, $time);
    end
  endtask

  task automatic set_row(input int idx, input string name, input int cycles, input int recv,
                         input int dmode, input int exp_s, input int exp_id0, input int exp_id1,
                         input bit drain, input bit account);
    row_name[idx]    = name;
    row_cycles[idx]  = cycles;
    row_recv[idx]    = recv;
    row_dmode[idx]   = dmode;
    row_exp_s[idx]   = exp_s;
    row_exp_id0[idx] = exp_id0;
    row_exp_id1[idx] = exp_id1;
    row_drain[idx]   = drain;
    row_account[idx] = account;
  endtask

  // Expected outputs belong to the last cycle of a row and are sampled before its transfer
  task automatic fill_table();
    // Lowest free entries 2 and 3 are offered one cycle after reset is released
    set_row(0, "reset_offer", 1, 0, D_NONE, 2, 2, 3, 1'b0, 1'b0);
    // Under back-pressure the offered pair holds
    set_row(1, "reset_hold", 2, 0, D_NONE, 2, 2, 3, 1'b0, 1'b0);
    // Full-rate drain empties the pool and staging
    set_row(2, "drain", 5, 2, D_NONE, 0, ANY, ANY, 1'b1, 1'b0);
    // Return entry 0 in cycle t and expect nothing to show until cycle t+2
    set_row(3, "cut_return", 1, 0, D_ONE, 0, ANY, ANY, 1'b0, 1'b0);
    set_row(4, "cut_gap", 1, 0, D_NONE, 0, ANY, ANY, 1'b0, 1'b0);
    set_row(5, "cut_offer", 1, 0, D_NONE, 1, 0, ANY, 1'b0, 1'b0);
    // Entries 1 and 2 come back while only one staging slot is left for them
    set_row(6, "pair_return", 1, 0, D_TWO, 1, 0, ANY, 1'b0, 1'b0);
    set_row(7, "pair_fill", 3, 0, D_NONE, 2, 0, 1, 1'b0, 1'b0);
    // Only symbol 0 goes so entry 1 moves down and entry 2 fills in above it
    set_row(8, "partial", 1, 1, D_NONE, 2, 0, 1, 1'b0, 1'b0);
    set_row(9, "after_partial", 1, 0, D_NONE, 2, 1, 2, 1'b0, 1'b0);
    set_row(10, "random_mix", 200, R_RANDOM, D_RANDOM, ANY, ANY, ANY, 1'b0, 1'b0);
    // Traffic stops and staging refills from whatever is free
    set_row(11, "settle", 4, 0, D_NONE, ANY, ANY, ANY, 1'b0, 1'b1);
  endtask

  function automatic int total_cycles();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      sum += row_cycles[i];
    end
    return sum;
  endfunction

  // Releases one held ID found by scanning up from entry 0 or from a random start
  task automatic pick_held(input bit random_start, output int id);
    int start;
    int idx;
    id = -1;
    start = 0;
    if (random_start) begin
      rng = xorshift(rng);
      start = int'(rng % 32'(`FL_NUM_ENTRIES));
    end
    for (int k = 0; k < `FL_NUM_ENTRIES; k++) begin
      idx = (start + k) % `FL_NUM_ENTRIES;
      if (id < 0 && held[idx]) begin
        id = idx;
      end
    end
    if (id >= 0) begin
      held[id] = 1'b0;
    end
  endtask

  // Sets the deallocation ports for one cycle and returns how many strobes are valid
  task automatic drive_deallocs(input int mode, output int num);
    int want;
    int id;
    want = mode;
    if (mode == D_RANDOM) begin
      rng = xorshift(rng);
      want = int'(rng % 32'd3);
    end
    dealloc_valid = '0;
    dealloc_ids   = '0;
    num = 0;
    for (int p = 0; p < want; p++) begin
      pick_held(mode == D_RANDOM, id);
      if (id >= 0) begin
        dealloc_valid[p] = 1'b1;
        dealloc_ids[p]   = freelist_pkg::entry_id_t'(id);
        num++;
      end
    end
  endtask

  // Checks and drives one clock cycle of a row at the falling edge
  task automatic run_cycle(input int row);
    int r;
    int n;
    int nd;
    int id;
    @(negedge clk);
    // DUT outputs all come from registers and settle right after the rising edge
    last_s = int'(alloc_sendable);
    for (int i = 0; i < `FL_NUM_ALLOC; i++) begin
      last_ids[i] = int'(alloc_ids[i]);
    end
    compare("dealloc_count", int'(dealloc_count), count_q.pop_front());
    compare("alloc_sendable <= FL_NUM_ALLOC", int'(last_s <= `FL_NUM_ALLOC), 1);
    // IDs left over from the previous offer now start at symbol 0 in the same order
    compare("alloc_sendable >= survivors", int'(last_s >= prev_left), 1);
    for (int i = 0; i < prev_left; i++) begin
      compare($sformatf("alloc_ids[%0d]", i), last_ids[i], prev_ids[i + prev_n]);
    end
    // An offered ID must not be one the user still holds
    for (int i = 0; i < last_s && i < `FL_NUM_ALLOC; i++) begin
      compare($sformatf("held[alloc_ids[%0d]]", i), int'(held[last_ids[i]]), 0);
    end
    if (last_s >= 2) begin
      compare("alloc_ids[1] != alloc_ids[0]", int'(last_ids[1] != last_ids[0]), 1);
    end
    r = row_recv[row];
    if (r == R_RANDOM) begin
      rng = xorshift(rng);
      r = int'(rng % 32'd3);
    end
    // Returns are picked before this cycle's transfers become held
    drive_deallocs(row_dmode[row], nd);
    alloc_receivable = freelist_pkg::alloc_count_t'(r);
    n = (last_s < r) ? last_s : r;
    // Symbols 0 to n-1 go to the user at the coming rising edge
    for (int i = 0; i < n; i++) begin
      id = last_ids[i];
      held[id] = 1'b1;
      if (row_drain[row]) begin
        drained_q.push_back(id);
      end
    end
    for (int i = 0; i < `FL_NUM_ALLOC; i++) begin
      prev_ids[i] = last_ids[i];
    end
    prev_n    = n;
    prev_left = last_s - n;
    count_q.push_back(nd);
  endtask

  task automatic check_row_end(input int row);
    int k;
    int free_count;
    int expect_s;
    if (row_exp_s[row] != ANY) begin
      compare("alloc_sendable", last_s, row_exp_s[row]);
    end
    if (row_exp_id0[row] != ANY) begin
      compare("alloc_ids[0]", last_ids[0], row_exp_id0[row]);
    end
    if (row_exp_id1[row] != ANY) begin
      compare("alloc_ids[1]", last_ids[1], row_exp_id1[row]);
    end
    // A drain hands out every entry that was free out of reset in ascending order and each once
    if (row_drain[row]) begin
      k = 0;
      for (int e = 0; e < `FL_NUM_ENTRIES; e++) begin
        if (!prealloc_mask[e]) begin
          if (k < drained_q.size()) begin
            compare($sformatf("drained ID %0d", k), drained_q[k], e);
          end
          k++;
        end
      end
      compare("drained ID count", drained_q.size(), k);
    end
    // Every entry not held is staged or waiting in the free vector and staging fills first
    if (row_account[row]) begin
      free_count = 0;
      for (int e = 0; e < `FL_NUM_ENTRIES; e++) begin
        if (!held[e]) begin
          free_count++;
        end
      end
      expect_s = (free_count < `FL_NUM_ALLOC) ? free_count : `FL_NUM_ALLOC;
      compare("alloc_sendable", last_s, expect_s);
    end
  endtask

  initial begin
    int errors_before;
    checks           = 0;
    errors           = 0;
    rng              = 32'h4ca7;
    rst_n            = 1'b0;
    alloc_receivable = '0;
    dealloc_valid    = '0;
    dealloc_ids      = '0;
    prealloc_mask    = `FL_PREALLOC;
    prev_n           = 0;
    prev_left        = 0;
    last_s           = 0;
    fill_table();
    table_ready = 1'b1;
    for (int e = 0; e < `FL_NUM_ENTRIES; e++) begin
      held[e] = prealloc_mask[e];
    end
    // Nothing was strobed in the cycles before the first check
    repeat (`FL_DEALLOC_COUNT_DELAY) count_q.push_back(0);
    repeat (RESET_CYCLES) @(negedge clk);
    // Both outputs are idle while reset is still applied
    compare("alloc_sendable", int'(alloc_sendable), 0);
    compare("dealloc_count", int'(dealloc_count), 0);
    $display("reset: %0d errors", errors);
    rst_n = 1'b1;
    for (int row = 0; row < NUM_ROWS; row++) begin
      errors_before = errors;
      drained_q.delete();
      for (int c = 0; c < row_cycles[row]; c++) begin
        run_cycle(row);
      end
      check_row_end(row);
      $display("row %0d %s: %0d cycles, %0d errors", row, row_name[row], row_cycles[row],
               errors - errors_before);
    end
    $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Allows twice the table length plus reset before the run is declared hung
  initial begin
    longint limit_ns;
    wait (table_ready);
    limit_ns = longint'(total_cycles()) * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: the stimulus table did not finish within %0d ns", limit_ns);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/freelist_pkg.sv
hdl/freelist_dealloc_decode.sv
hdl/freelist_free_vector.sv
hdl/freelist_alloc_stage.sv
hdl/freelist_top.sv
verif/freelist_tb.sv

// ==== Makefile ====
TOP = freelist_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f build.f -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^sim passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
